/* all.f */
hdl/vdp_pkg.sv
hdl/vdp_register.sv
hdl/vdp_vram_access.sv
hdl/vdp_interrupt.sv
hdl/vdp_color_out.sv
hdl/vdp_top.sv
bench/tb_vdp.sv

/* run.sh */
#!/bin/sh
# Build the VDP testbench with Verilator and run it; exit status follows the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_vdp -f all.f -o tb_vdp \
  && ./obj_dir/tb_vdp | tee /dev/stderr | grep -qF '*** PASSED ***' \
  && echo "Simulation run OK" \
  || { echo "Simulation run did not pass"; exit 1; }

/* bench/tb_vdp.sv */
// VDP core directed testbench
// CPU port tasks with REQ/ACK handshake, byte-wide VRAM model,
// palette, scanline and interrupt checks against the port rules

`timescale 1ns/1ps

module tb_vdp
  import vdp_pkg::*;
();

  // Longest test is the VRAM pass, about 40 accesses of under 10 cycles,
  // so the whole run stays near 1000 cycles
  localparam int TIMEOUT_CYCLES = 20000;

  logic       RESET = 1'b0;
  logic       CLK21M;
  logic       req, wrt, scanlin;
  logic [1:0] mode;
  byte_t      dbo, dbi;
  byte_t      vram_din = '0;
  beam_t      cx, cy;
  logic       ack, int_n, vram_we_n;
  vram_addr_t vram_adr;
  byte_t      vram_dout;
  rgb_chan_t  red, green, blue;

  byte_t       vram [16384];
  logic [31:0] lfsr = 32'h1078;
  int          cycles = 0;

  vdp_top uut (
    .RESET(RESET), .CLK21M(CLK21M),
    .req(req), .wrt(wrt), .mode(mode), .dbo(dbo), .vram_din(vram_din),
    .cx(cx), .cy(cy), .scanlin(scanlin),
    .ack(ack), .dbi(dbi), .int_n(int_n),
    .vram_adr(vram_adr), .vram_we_n(vram_we_n), .vram_dout(vram_dout),
    .red(red), .green(green), .blue(blue)
  );

  // Clock on RESET with a 100 ns period
  always #50 RESET = ~RESET;

  // --------------------
  // VRAM model and timeout
  // --------------------
  initial begin
    for (int i = 0; i < 16384; i++) vram[i] = byte_t'(i ^ (i >> 8));
  end

  // One-cycle read and a write on the strobe
  always @(posedge RESET) begin
    if (!vram_we_n) vram[vram_adr] <= vram_dout;
    vram_din <= vram[vram_adr];
  end

  always @(posedge RESET) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("*** FAILED ***");
      $fatal(1, "simulation stopped by timeout");
    end
  end

  // --------------------
  // Helpers
  // --------------------
  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERR %s expected %0h actual %0h", name, expected, actual);
      $display("*** FAILED ***");
      $fatal(1, "value mismatch");
    end
  endtask

  // Galois form with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand_byte(output byte_t b);
    b = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_next(lfsr);
      b = {b[6:0], lfsr[0]};
    end
  endtask

  // 3-bit channel repeated out to 8 bits and halved when dimmed
  function automatic rgb_chan_t widen(input logic [2:0] c, input logic half);
    rgb_chan_t full;
    full = (rgb_chan_t'(c) << 5) | (rgb_chan_t'(c) << 2) | (rgb_chan_t'(c) >> 1);
    return half ? (full >> 1) : full;
  endfunction

  // One handshake that holds inputs until ack and then drops req
  task automatic cpu_access(input logic [1:0] port, input logic wr, input byte_t d,
                            output byte_t q);
    @(posedge RESET);
    req  <= 1'b1;
    wrt  <= wr;
    mode <= port;
    dbo  <= d;
    do @(negedge RESET); while (!ack);
    q = dbi;
    @(posedge RESET);
    req <= 1'b0;
  endtask

  task automatic cpu_write(input logic [1:0] port, input byte_t d);
    byte_t unused;
    cpu_access(port, 1'b1, d, unused);
  endtask

  task automatic cpu_read(input logic [1:0] port, output byte_t q);
    cpu_access(port, 1'b0, 8'h00, q);
  endtask

  task automatic set_reg(input reg_num_t num, input byte_t val);
    cpu_write(PORT_CTRL, val);
    cpu_write(PORT_CTRL, {3'b100, num});
  endtask

  task automatic set_addr(input vram_addr_t a);
    cpu_write(PORT_CTRL, a[7:0]);
    cpu_write(PORT_CTRL, {2'b01, a[13:8]});
  endtask

  task automatic settle(input int n);
    repeat (n) @(posedge RESET);
    @(negedge RESET);
  endtask

  task automatic check_rgb(input string name, input logic [8:0] rgb, input logic half);
    check({name, " red"}, widen(rgb[8:6], half), red);
    check({name, " green"}, widen(rgb[5:3], half), green);
    check({name, " blue"}, widen(rgb[2:0], half), blue);
  endtask

  // Put the beam on a line at CX 0 for one cycle, then park it
  task automatic beam_hit(input beam_t line);
    @(posedge RESET);
    cy <= line;
    cx <= '0;
    @(posedge RESET);
    cx <= 10'd5;
    cy <= 10'd100;
    @(negedge RESET);
  endtask

  // --------------------
  // Tests
  // --------------------
  task automatic test_reset;
    check("reset ack", 0, ack);
    check("reset int_n", 1, int_n);
    check("reset vram_we_n", 1, vram_we_n);
    check("reset rgb", 0, {red, green, blue});
  endtask

  task automatic test_vram;
    byte_t      vals [16];
    byte_t      q;
    vram_addr_t base;
    base = 14'h0A50;
    set_addr(base);
    for (int i = 0; i < 16; i++) begin
      rand_byte(vals[i]);
      cpu_write(PORT_DATA, vals[i]);
    end
    @(negedge RESET);
    check("vram write increment", base + 14'd16, vram_adr);
    for (int i = 0; i < 16; i++) check("vram model contents", vals[i], vram[base + i]);
    set_addr(base);
    for (int i = 0; i < 16; i++) begin
      cpu_read(PORT_DATA, q);
      check("vram read-back", vals[i], q);
    end
    @(negedge RESET);
    check("vram read increment", base + 14'd16, vram_adr);
  endtask

  task automatic test_palette;
    set_reg(REG_PAL_PTR, 8'd3);
    // Entry 3 red 5 green 2 blue 6, entry 4 red 3 green 7 blue 1
    cpu_write(PORT_PAL, 8'h56);
    cpu_write(PORT_PAL, 8'h02);
    cpu_write(PORT_PAL, 8'h31);
    cpu_write(PORT_PAL, 8'h07);
    set_reg(REG_BACKDROP, 8'd3);
    settle(2);
    check_rgb("palette entry 3", {3'd5, 3'd2, 3'd6}, 1'b0);
    set_reg(REG_BACKDROP, 8'd4);
    settle(2);
    check_rgb("palette entry 4", {3'd3, 3'd7, 3'd1}, 1'b0);
  endtask

  task automatic test_scanline;
    @(posedge RESET);
    scanlin <= 1'b1;
    cy      <= 10'd101;
    settle(2);
    check_rgb("scanline odd", {3'd3, 3'd7, 3'd1}, 1'b1);
    @(posedge RESET);
    cy <= 10'd102;
    settle(2);
    check_rgb("scanline even", {3'd3, 3'd7, 3'd1}, 1'b0);
    @(posedge RESET);
    scanlin <= 1'b0;
    cy      <= 10'd100;
  endtask

  task automatic test_vblank;
    byte_t s;
    set_reg(REG_STATUS_SEL, 8'd0);
    set_reg(REG_MODE1, 8'h20);
    beam_hit(VBLANK_LINE);
    check("vblank int_n low", 0, int_n);
    cpu_read(PORT_CTRL, s);
    check("vblank S0 bit 7", 1, s[7]);
    @(negedge RESET);
    check("vblank cleared by S0", 1, int_n);
    // Flag still sets with the enable off, but int_n must not move
    set_reg(REG_MODE1, 8'h00);
    beam_hit(VBLANK_LINE);
    settle(3);
    check("vblank masked int_n", 1, int_n);
    cpu_read(PORT_CTRL, s);
    check("vblank masked S0 bit 7", 1, s[7]);
  endtask

  task automatic test_line_int;
    byte_t s;
    set_reg(REG_STATUS_SEL, 8'd1);
    set_reg(REG_LINE_INT, 8'd60);
    set_reg(REG_MODE0, 8'h10);
    beam_hit(10'd120);
    check("line int_n low", 0, int_n);
    cpu_read(PORT_CTRL, s);
    check("line S1 bit 0", 1, s[0]);
    @(negedge RESET);
    check("line cleared by S1", 1, int_n);
  endtask

  initial begin
    CLK21M  = 1'b1;
    req     = 1'b0;
    wrt     = 1'b0;
    mode    = PORT_DATA;
    dbo     = '0;
    cx      = 10'd5;
    cy      = 10'd100;
    scanlin = 1'b0;
    repeat (8) @(posedge RESET);
    CLK21M <= 1'b0;
    settle(1);
    test_reset();
    test_vram();
    test_palette();
    test_scanline();
    test_vblank();
    test_line_int();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* hdl/vdp_top.sv */
// VDP core top level
// CPU register port, VRAM scheduler, interrupt flags and
// backdrop colour output; beam position comes from outside

`timescale 1ns/1ps

module vdp_top
  import vdp_pkg::*;
(
  input  logic       RESET,
  input  logic       CLK21M,
  input  logic       req,
  input  logic       wrt,
  input  logic [1:0] mode,
  input  byte_t      dbo,
  input  byte_t      vram_din,
  input  beam_t      cx,
  input  beam_t      cy,
  input  logic       scanlin,
  output logic       ack,
  output byte_t      dbi,
  output logic       int_n,
  output vram_addr_t vram_adr,
  output logic       vram_we_n,
  output byte_t      vram_dout,
  output rgb_chan_t  red,
  output rgb_chan_t  green,
  output rgb_chan_t  blue
);

  // Register block to VRAM scheduler
  logic       vram_req, vram_wr, vram_done;
  vram_addr_t vram_addr;
  byte_t      vram_wdata, vram_rdata;

  // Interrupt control
  logic       vblank_flag, line_flag, clr_vblank, clr_line;
  logic       vblank_int_en, line_int_en;
  byte_t      line_int_num;

  // Palette and backdrop
  pal_idx_t   backdrop, pal_idx;
  logic       pal_we;
  pal_rgb_t   pal_data;

  vdp_register u_register (
    .RESET(RESET), .CLK21M(CLK21M),
    .req(req), .wrt(wrt), .mode(mode), .dbo(dbo),
    .vram_rdata(vram_rdata), .vram_done(vram_done),
    .vblank_flag(vblank_flag), .line_flag(line_flag),
    .ack(ack), .dbi(dbi),
    .vram_req(vram_req), .vram_wr(vram_wr),
    .vram_addr(vram_addr), .vram_wdata(vram_wdata),
    .clr_vblank(clr_vblank), .clr_line(clr_line),
    .vblank_int_en(vblank_int_en), .line_int_en(line_int_en),
    .line_int_num(line_int_num), .backdrop(backdrop),
    .pal_we(pal_we), .pal_idx(pal_idx), .pal_data(pal_data)
  );

  vdp_vram_access u_vram_access (
    .RESET(RESET), .CLK21M(CLK21M),
    .vram_req(vram_req), .vram_wr(vram_wr),
    .vram_addr(vram_addr), .vram_wdata(vram_wdata),
    .vram_din(vram_din), .vram_done(vram_done), .vram_rdata(vram_rdata),
    .vram_adr(vram_adr), .vram_we_n(vram_we_n), .vram_dout(vram_dout)
  );

  vdp_interrupt u_interrupt (
    .RESET(RESET), .CLK21M(CLK21M),
    .cx(cx), .cy(cy), .line_int_num(line_int_num),
    .vblank_int_en(vblank_int_en), .line_int_en(line_int_en),
    .clr_vblank(clr_vblank), .clr_line(clr_line),
    .vblank_flag(vblank_flag), .line_flag(line_flag), .int_n(int_n)
  );

  vdp_color_out u_color_out (
    .RESET(RESET), .CLK21M(CLK21M),
    .cy(cy), .scanlin(scanlin), .backdrop(backdrop),
    .pal_we(pal_we), .pal_idx(pal_idx), .pal_data(pal_data),
    .red(red), .green(green), .blue(blue)
  );

endmodule

/* hdl/vdp_color_out.sv */
// VDP colour output
// 16-entry palette RAM, backdrop lookup and 3-to-8 bit expansion
// with optional dimming of odd scanlines, registered RGB out

`timescale 1ns/1ps

module vdp_color_out
  import vdp_pkg::*;
(
  input  logic      RESET,
  input  logic      CLK21M,
  input  beam_t     cy,
  input  logic      scanlin,
  input  pal_idx_t  backdrop,
  input  logic      pal_we,
  input  pal_idx_t  pal_idx,
  input  pal_rgb_t  pal_data,
  output rgb_chan_t red,
  output rgb_chan_t green,
  output rgb_chan_t blue
);

  pal_rgb_t pal_ram [16];
  pal_rgb_t entry;
  logic     dim;

  // Bit repeat, then halve when dimmed
  function automatic rgb_chan_t expand(input logic [2:0] c, input logic half);
    rgb_chan_t full;
    full = {c, c, c[2:1]};
    return half ? {1'b0, full[7:1]} : full;
  endfunction

  assign entry = pal_ram[backdrop];
  assign dim   = scanlin && cy[0];

  // --------------------
  // Palette and output
  // --------------------
  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      for (int i = 0; i < 16; i++) pal_ram[i] <= '0;
      red   <= '0;
      green <= '0;
      blue  <= '0;
    end else begin
      if (pal_we) pal_ram[pal_idx] <= pal_data;
      red   <= expand(entry[8:6], dim);
      green <= expand(entry[5:3], dim);
      blue  <= expand(entry[2:0], dim);
    end
  end

endmodule

/* hdl/vdp_interrupt.sv */
// VDP interrupt flags
// Vertical-blank and line flags set from the beam position,
// cleared by status reads, combined with their enables into int_n

`timescale 1ns/1ps

module vdp_interrupt
  import vdp_pkg::*;
(
  input  logic  RESET,
  input  logic  CLK21M,
  input  beam_t cx,
  input  beam_t cy,
  input  byte_t line_int_num,
  input  logic  vblank_int_en,
  input  logic  line_int_en,
  input  logic  clr_vblank,
  input  logic  clr_line,
  output logic  vblank_flag,
  output logic  line_flag,
  output logic  int_n
);

  logic vblank_hit;
  logic line_hit;

  // Line register counts in half-lines of CY
  assign vblank_hit = (cy == VBLANK_LINE) && (cx == '0);
  assign line_hit   = (cy[9:1] == {1'b0, line_int_num}) && (cx == '0);

  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      vblank_flag <= 1'b0;
      line_flag   <= 1'b0;
    end else begin
      // Clear wins over a set in the same cycle
      if (clr_vblank) vblank_flag <= 1'b0;
      else if (vblank_hit) vblank_flag <= 1'b1;
      if (clr_line) line_flag <= 1'b0;
      else if (line_hit) line_flag <= 1'b1;
    end
  end

  assign int_n = !((vblank_flag && vblank_int_en) || (line_flag && line_int_en));

endmodule

/* hdl/vdp_vram_access.sv */
// VDP VRAM access scheduler
// Free-running dot-state counter with one CPU slot per four dots;
// a pending CPU request is put on the VRAM bus only in that slot

`timescale 1ns/1ps

module vdp_vram_access
  import vdp_pkg::*;
(
  input  logic       RESET,
  input  logic       CLK21M,
  input  logic       vram_req,
  input  logic       vram_wr,
  input  vram_addr_t vram_addr,
  input  byte_t      vram_wdata,
  input  byte_t      vram_din,
  output logic       vram_done,
  output byte_t      vram_rdata,
  output vram_addr_t vram_adr,
  output logic       vram_we_n,
  output byte_t      vram_dout
);

  dot_state_t dot_state;
  logic       rd_pend;
  logic       slot_hit;

  // --------------------
  // Slot decode
  // --------------------
  // A served request is dropped before the slot comes round again
  assign slot_hit = vram_req && (dot_state == CPU_SLOT);

  // Address and data sit on the bus, the strobe only in the slot
  assign vram_adr  = vram_addr;
  assign vram_dout = vram_wdata;
  assign vram_we_n = !(slot_hit && vram_wr);

  // --------------------
  // Dot counter and completion
  // --------------------
  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      dot_state <= '0;
      rd_pend   <= 1'b0;
      vram_done <= 1'b0;
    end else begin
      dot_state <= dot_state + 1'b1;
      // Write completes in the slot, read one cycle later
      rd_pend   <= slot_hit && !vram_wr;
      vram_done <= (slot_hit && vram_wr) || rd_pend;
    end
  end

  // VRAM returns data one cycle after the address
  always_ff @(posedge RESET) begin
    if (rd_pend) vram_rdata <= vram_din;
  end

endmodule

/* hdl/vdp_register.sv */
// VDP CPU interface and control registers
// Decodes the four CPU ports, runs the two-byte control sequence,
// forwards data-port accesses to the VRAM scheduler and feeds the palette

`timescale 1ns/1ps

module vdp_register
  import vdp_pkg::*;
(
  input  logic       RESET,
  input  logic       CLK21M,
  input  logic       req,
  input  logic       wrt,
  input  logic [1:0] mode,
  input  byte_t      dbo,
  input  byte_t      vram_rdata,
  input  logic       vram_done,
  input  logic       vblank_flag,
  input  logic       line_flag,
  output logic       ack,
  output byte_t      dbi,
  output logic       vram_req,
  output logic       vram_wr,
  output vram_addr_t vram_addr,
  output byte_t      vram_wdata,
  output logic       clr_vblank,
  output logic       clr_line,
  output logic       vblank_int_en,
  output logic       line_int_en,
  output byte_t      line_int_num,
  output pal_idx_t   backdrop,
  output logic       pal_we,
  output pal_idx_t   pal_idx,
  output pal_rgb_t   pal_data
);

  cpu_state_t state;
  byte_t      regs [NUM_REGS];
  byte_t      ctrl_latch;
  logic       ctrl_first;
  byte_t      pal_rb;
  logic       pal_first;
  pal_idx_t   pal_ptr;
  byte_t      status;
  reg_num_t   wr_num;
  logic       start, data_acc, ctrl_wr, ctrl_rd, pal_wr, reg_wr, addr_set;

  // --------------------
  // Port decode
  // --------------------
  assign start    = (state == CPU_IDLE) && req;
  assign data_acc = start && (mode == PORT_DATA);
  assign ctrl_wr  = start && (mode == PORT_CTRL) && wrt;
  assign ctrl_rd  = start && (mode == PORT_CTRL) && !wrt;
  assign pal_wr   = start && (mode == PORT_PAL) && wrt;
  // Second control byte 10 writes a register and 01 sets the VRAM address
  assign wr_num   = dbo[4:0];
  assign reg_wr   = ctrl_wr && ctrl_first && (dbo[7:6] == 2'b10);
  assign addr_set = ctrl_wr && ctrl_first && (dbo[7:6] == 2'b01);

  assign vblank_int_en = regs[REG_MODE1][5];
  assign line_int_en   = regs[REG_MODE0][4];
  assign line_int_num  = regs[REG_LINE_INT];
  assign backdrop      = regs[REG_BACKDROP][3:0];

  always_comb begin
    case (regs[REG_STATUS_SEL])
      8'd0:    status = {vblank_flag, 7'b0};
      8'd1:    status = {7'b0, line_flag};
      default: status = '0;
    endcase
  end

  // --------------------
  // Access FSM
  // --------------------
  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      state      <= CPU_IDLE;
      ack        <= 1'b0;
      dbi        <= '0;
      vram_req   <= 1'b0;
      vram_wr    <= 1'b0;
      clr_vblank <= 1'b0;
      clr_line   <= 1'b0;
    end else begin
      ack        <= 1'b0;
      clr_vblank <= ctrl_rd && (regs[REG_STATUS_SEL] == 8'd0);
      clr_line   <= ctrl_rd && (regs[REG_STATUS_SEL] == 8'd1);
      case (state)
        CPU_IDLE: begin
          if (data_acc) begin
            vram_req <= 1'b1;
            vram_wr  <= wrt;
            state    <= wrt ? CPU_WAIT_SLOT : CPU_READ_DATA;
          end else if (start) begin
            // Register and palette ports answer at once
            ack   <= 1'b1;
            dbi   <= ctrl_rd ? status : '0;
            state <= CPU_DONE;
          end
        end
        CPU_WAIT_SLOT: begin
          if (vram_done) begin
            vram_req <= 1'b0;
            ack      <= 1'b1;
            state    <= CPU_DONE;
          end
        end
        CPU_READ_DATA: begin
          if (vram_done) begin
            vram_req <= 1'b0;
            ack      <= 1'b1;
            dbi      <= vram_rdata;
            state    <= CPU_DONE;
          end
        end
        // Hold until the CPU drops req
        CPU_DONE: if (!req) state <= CPU_IDLE;
        default:  state <= CPU_IDLE;
      endcase
    end
  end

  always_ff @(posedge RESET) begin
    if (data_acc) vram_wdata <= dbo;
  end

  // --------------------
  // Register file and address counter
  // --------------------
  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      ctrl_first <= 1'b0;
      ctrl_latch <= '0;
      vram_addr  <= '0;
      for (int i = 0; i < NUM_REGS; i++) regs[i] <= '0;
    end else begin
      // A status read restarts the byte pairing
      if (ctrl_rd) begin
        ctrl_first <= 1'b0;
      end else if (ctrl_wr) begin
        ctrl_first <= !ctrl_first;
        if (!ctrl_first) ctrl_latch <= dbo;
      end
      if (reg_wr && (wr_num < NUM_REGS)) regs[wr_num] <= ctrl_latch;
      if (addr_set) begin
        vram_addr <= {dbo[5:0], ctrl_latch};
      end else if (vram_done) begin
        vram_addr <= vram_addr + 1'b1;
      end
    end
  end

  // Palette entry built from a red/blue byte and then a green byte
  always_ff @(posedge RESET or posedge CLK21M) begin
    if (CLK21M) begin
      pal_first <= 1'b0;
      pal_rb    <= '0;
      pal_ptr   <= '0;
      pal_we    <= 1'b0;
      pal_idx   <= '0;
      pal_data  <= '0;
    end else begin
      pal_we <= 1'b0;
      if (reg_wr && (wr_num == REG_PAL_PTR)) begin
        pal_ptr   <= ctrl_latch[3:0];
        pal_first <= 1'b0;
      end else if (pal_wr && !pal_first) begin
        pal_rb    <= dbo;
        pal_first <= 1'b1;
      end else if (pal_wr) begin
        pal_we    <= 1'b1;
        pal_idx   <= pal_ptr;
        pal_data  <= {pal_rb[6:4], dbo[2:0], pal_rb[2:0]};
        pal_ptr   <= pal_ptr + 1'b1;
        pal_first <= 1'b0;
      end
    end
  end

endmodule

/* hdl/vdp_pkg.sv */
// VDP core shared definitions
// Widths, CPU port codes, register numbers and beam constants
// used across the register, VRAM, interrupt and colour blocks

package vdp_pkg;

  // --------------------
  // Widths
  // --------------------
  typedef logic [7:0]  byte_t;
  typedef logic [13:0] vram_addr_t;
  typedef logic [4:0]  reg_num_t;
  typedef logic [3:0]  pal_idx_t;
  // Red [8:6], green [5:3], blue [2:0]
  typedef logic [8:0]  pal_rgb_t;
  typedef logic [9:0]  beam_t;
  typedef logic [1:0]  dot_state_t;
  typedef logic [7:0]  rgb_chan_t;

  // CPU access sequencing
  typedef enum logic [1:0] {
    CPU_IDLE,
    CPU_WAIT_SLOT,
    CPU_READ_DATA,
    CPU_DONE
  } cpu_state_t;

  // --------------------
  // CPU port codes
  // --------------------
  localparam logic [1:0] PORT_DATA = 2'd0;
  localparam logic [1:0] PORT_CTRL = 2'd1;
  localparam logic [1:0] PORT_PAL  = 2'd2;

  // Register numbers
  localparam reg_num_t REG_MODE0      = 5'd0;
  localparam reg_num_t REG_MODE1      = 5'd1;
  localparam reg_num_t REG_BACKDROP   = 5'd7;
  localparam reg_num_t REG_STATUS_SEL = 5'd15;
  localparam reg_num_t REG_PAL_PTR    = 5'd16;
  localparam reg_num_t REG_LINE_INT   = 5'd19;
  localparam int       NUM_REGS       = 24;

  // Beam and access timing
  localparam beam_t      VBLANK_LINE = 10'd424;
  localparam dot_state_t CPU_SLOT    = 2'd1;

endpackage
